//--- verilog/front_pkg.sv
package front_pkg;

	//////////////////////////////////////////////////
	// shared widths
	//////////////////////////////////////////////////

	// byte address width
	localparam int xlen = 32;
	// one memory word, also one cache line
	localparam int line_bits = 64;
	// response and return tags, zero means none
	localparam int tag_bits = 4;

	//////////////////////////////////////////////////
	// encodings
	//////////////////////////////////////////////////

	// command on the tagged memory bus
	typedef enum logic [1:0] {
		bus_none  = 2'h0,
		bus_load  = 2'h1,
		bus_store = 2'h2
	} bus_command_e;

	// icache miss handling
	typedef enum logic [1:0] {
		fill_idle,
		fill_request,
		fill_wait
	} fill_state_e;

	// data port transaction
	typedef enum logic [1:0] {
		port_idle,
		port_request,
		port_wait
	} port_state_e;

endpackage

//--- verilog/icache.sv
`timescale 1ns/1ps

module icache #(
	parameter int num_lines = 16
) (
	input  logic                              clock,
	input  logic                              reset,
	// fetch side
	input  logic [front_pkg::xlen-1:0]        fetch_addr,
	output logic [front_pkg::line_bits-1:0]   fetch_data,
	output logic                              fetch_valid,
	// request toward the arbiter
	output front_pkg::bus_command_e           imem_command,
	output logic [front_pkg::xlen-1:0]        imem_addr,
	input  logic [front_pkg::tag_bits-1:0]    icache_response,
	// return path, shared with the data side
	input  logic [front_pkg::tag_bits-1:0]    mem2proc_tag,
	input  logic [front_pkg::line_bits-1:0]   mem2proc_data
);

	// 8-byte offset, then index, then address tag
	localparam int offset_bits = 3;
	localparam int index_bits = $clog2(num_lines);
	localparam int addr_tag_bits = front_pkg::xlen - offset_bits - index_bits;

	//////////////////////////////////////////////////
	// line storage
	//////////////////////////////////////////////////

	logic [front_pkg::line_bits-1:0] line_data [num_lines];
	logic [addr_tag_bits-1:0]        line_tag [num_lines];
	logic [num_lines-1:0]            line_valid;

	// lookup fields of the current fetch
	logic [index_bits-1:0]    fetch_index;
	logic [addr_tag_bits-1:0] fetch_tag;
	logic                     hit;

	// one miss outstanding
	front_pkg::fill_state_e          state;
	logic [front_pkg::xlen-1:0]      miss_addr;
	logic [front_pkg::tag_bits-1:0]  miss_bus_tag;
	logic [index_bits-1:0]           miss_index;
	logic [addr_tag_bits-1:0]        miss_addr_tag;

	assign fetch_index = fetch_addr[offset_bits +: index_bits];
	assign fetch_tag = fetch_addr[front_pkg::xlen-1 -: addr_tag_bits];

	// combinational hit, same cycle as fetch_addr
	assign hit = line_valid[fetch_index] && (line_tag[fetch_index] == fetch_tag);
	assign fetch_valid = hit;
	assign fetch_data = line_data[fetch_index];

	// where the refill lands
	assign miss_index = miss_addr[offset_bits +: index_bits];
	assign miss_addr_tag = miss_addr[front_pkg::xlen-1 -: addr_tag_bits];

	// load request only while waiting for acceptance
	assign imem_command = (state == front_pkg::fill_request) ?
		front_pkg::bus_load : front_pkg::bus_none;
	assign imem_addr = miss_addr;

	//////////////////////////////////////////////////
	// miss FSM
	//////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= front_pkg::fill_idle;
			line_valid <= '0;
		end else begin
			case (state)
				front_pkg::fill_idle: begin
					// capture aligned address of the missing word
					if (!hit) begin
						state <= front_pkg::fill_request;
						miss_addr <= {fetch_addr[front_pkg::xlen-1:offset_bits],
							{offset_bits{1'b0}}};
					end
				end
				front_pkg::fill_request: begin
					// nonzero response is our tag
					if (icache_response != '0) begin
						miss_bus_tag <= icache_response;
						state <= front_pkg::fill_wait;
					end
				end
				front_pkg::fill_wait: begin
					// other tags belong to the data side
					if (mem2proc_tag == miss_bus_tag) begin
						line_data[miss_index] <= mem2proc_data;
						line_tag[miss_index] <= miss_addr_tag;
						line_valid[miss_index] <= 1'b1;
						state <= front_pkg::fill_idle;
					end
				end
				default: begin
					state <= front_pkg::fill_idle;
				end
			endcase
		end
	end

endmodule

//--- verilog/data_port.sv
`timescale 1ns/1ps

module data_port (
	input  logic                              clock,
	input  logic                              reset,
	// client request
	input  logic                              req_valid,
	input  logic                              req_store,
	input  logic [front_pkg::xlen-1:0]        req_addr,
	input  logic [front_pkg::line_bits-1:0]   req_data,
	output logic                              req_ready,
	// load completion
	output logic                              resp_valid,
	output logic [front_pkg::line_bits-1:0]   resp_data,
	// request toward the arbiter
	output front_pkg::bus_command_e           dmem_command,
	output logic [front_pkg::xlen-1:0]        dmem_addr,
	output logic [front_pkg::line_bits-1:0]   dmem_data,
	input  logic [front_pkg::tag_bits-1:0]    dcache_response,
	// return path, shared with the icache
	input  logic [front_pkg::tag_bits-1:0]    mem2proc_tag,
	input  logic [front_pkg::line_bits-1:0]   mem2proc_data
);

	//////////////////////////////////////////////////
	// transaction state
	//////////////////////////////////////////////////

	front_pkg::port_state_e state;

	// latched request
	logic                            held_store;
	logic [front_pkg::xlen-1:0]      held_addr;
	logic [front_pkg::line_bits-1:0] held_data;

	// tag of the outstanding load
	logic [front_pkg::tag_bits-1:0]  load_tag;

	// one transaction at a time
	assign req_ready = (state == front_pkg::port_idle);

	// drive the bus request until accepted
	always_comb begin
		dmem_command = front_pkg::bus_none;
		if (state == front_pkg::port_request) begin
			dmem_command = held_store ? front_pkg::bus_store : front_pkg::bus_load;
		end
	end
	assign dmem_addr = held_addr;
	assign dmem_data = held_data;

	//////////////////////////////////////////////////
	// port FSM
	//////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= front_pkg::port_idle;
			resp_valid <= 1'b0;
		end else begin
			// single-cycle pulse by default
			resp_valid <= 1'b0;
			case (state)
				front_pkg::port_idle: begin
					if (req_valid) begin
						held_store <= req_store;
						held_addr <= req_addr;
						held_data <= req_data;
						state <= front_pkg::port_request;
					end
				end
				front_pkg::port_request: begin
					if (dcache_response != '0) begin
						// store done at acceptance
						if (held_store) begin
							state <= front_pkg::port_idle;
						end else begin
							load_tag <= dcache_response;
							state <= front_pkg::port_wait;
						end
					end
				end
				front_pkg::port_wait: begin
					// returned word, one cycle later on resp
					if (mem2proc_tag == load_tag) begin
						resp_valid <= 1'b1;
						resp_data <= mem2proc_data;
						state <= front_pkg::port_idle;
					end
				end
				default: begin
					state <= front_pkg::port_idle;
				end
			endcase
		end
	end

endmodule

//--- verilog/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter (
	input  logic                              clock,
	input  logic                              reset,
	// instruction side
	input  front_pkg::bus_command_e           imem_command,
	input  logic [front_pkg::xlen-1:0]        imem_addr,
	// data side
	input  front_pkg::bus_command_e           dmem_command,
	input  logic [front_pkg::xlen-1:0]        dmem_addr,
	input  logic [front_pkg::line_bits-1:0]   dmem_data,
	// accepted tag back to each side
	output logic [front_pkg::tag_bits-1:0]    icache_response,
	output logic [front_pkg::tag_bits-1:0]    dcache_response,
	// memory bus
	output front_pkg::bus_command_e           proc2mem_command,
	output logic [front_pkg::xlen-1:0]        proc2mem_addr,
	output logic [front_pkg::line_bits-1:0]   proc2mem_data,
	input  logic [front_pkg::tag_bits-1:0]    mem2proc_response
);

	// who loaded the bus register, 1 for data
	logic owner_data;

	logic accepted;
	logic reg_free;
	logic d_pending;
	logic i_pending;

	// nonzero response on a live command
	assign accepted = (proc2mem_command != front_pkg::bus_none) && (mem2proc_response != '0);
	assign reg_free = (proc2mem_command == front_pkg::bus_none) || accepted;

	// accepted side still shows its request this cycle
	assign d_pending = (dmem_command != front_pkg::bus_none) && !(accepted && owner_data);
	assign i_pending = (imem_command != front_pkg::bus_none) && !(accepted && !owner_data);

	// response only to the owner
	assign dcache_response = (accepted && owner_data) ? mem2proc_response : '0;
	assign icache_response = (accepted && !owner_data) ? mem2proc_response : '0;

	//////////////////////////////////////////////////
	// bus register
	//////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			proc2mem_command <= front_pkg::bus_none;
			owner_data <= 1'b0;
		end else if (reg_free) begin
			// data side first
			if (d_pending) begin
				proc2mem_command <= dmem_command;
				proc2mem_addr <= dmem_addr;
				proc2mem_data <= dmem_data;
				owner_data <= 1'b1;
			end else if (i_pending) begin
				proc2mem_command <= imem_command;
				proc2mem_addr <= imem_addr;
				// no write data on instruction loads
				proc2mem_data <= '0;
				owner_data <= 1'b0;
			end else begin
				proc2mem_command <= front_pkg::bus_none;
			end
		end
	end

endmodule

//--- verilog/mem_front.sv
`timescale 1ns/1ps

module mem_front #(
	parameter int num_lines = 16
) (
	input  logic                              clock,
	input  logic                              reset,
	// fetch client
	input  logic [front_pkg::xlen-1:0]        fetch_addr,
	output logic [front_pkg::line_bits-1:0]   fetch_data,
	output logic                              fetch_valid,
	// data client
	input  logic                              req_valid,
	input  logic                              req_store,
	input  logic [front_pkg::xlen-1:0]        req_addr,
	input  logic [front_pkg::line_bits-1:0]   req_data,
	output logic                              req_ready,
	output logic                              resp_valid,
	output logic [front_pkg::line_bits-1:0]   resp_data,
	// memory bus
	output front_pkg::bus_command_e           proc2mem_command,
	output logic [front_pkg::xlen-1:0]        proc2mem_addr,
	output logic [front_pkg::line_bits-1:0]   proc2mem_data,
	input  logic [front_pkg::tag_bits-1:0]    mem2proc_response,
	input  logic [front_pkg::tag_bits-1:0]    mem2proc_tag,
	input  logic [front_pkg::line_bits-1:0]   mem2proc_data
);

	//////////////////////////////////////////////////
	// side requests into the arbiter
	//////////////////////////////////////////////////

	front_pkg::bus_command_e         imem_command;
	logic [front_pkg::xlen-1:0]      imem_addr;
	front_pkg::bus_command_e         dmem_command;
	logic [front_pkg::xlen-1:0]      dmem_addr;
	logic [front_pkg::line_bits-1:0] dmem_data;
	// accepted tags back out
	logic [front_pkg::tag_bits-1:0]  icache_response;
	logic [front_pkg::tag_bits-1:0]  dcache_response;

	// instruction side
	icache #(
		.num_lines(num_lines)
	) icache_0 (
		.clock(clock),
		.reset(reset),
		.fetch_addr(fetch_addr),
		.fetch_data(fetch_data),
		.fetch_valid(fetch_valid),
		.imem_command(imem_command),
		.imem_addr(imem_addr),
		.icache_response(icache_response),
		.mem2proc_tag(mem2proc_tag),
		.mem2proc_data(mem2proc_data)
	);

	// data side
	data_port data_port_0 (
		.clock(clock),
		.reset(reset),
		.req_valid(req_valid),
		.req_store(req_store),
		.req_addr(req_addr),
		.req_data(req_data),
		.req_ready(req_ready),
		.resp_valid(resp_valid),
		.resp_data(resp_data),
		.dmem_command(dmem_command),
		.dmem_addr(dmem_addr),
		.dmem_data(dmem_data),
		.dcache_response(dcache_response),
		.mem2proc_tag(mem2proc_tag),
		.mem2proc_data(mem2proc_data)
	);

	// merge onto the single bus
	mem_arbiter mem_arbiter_0 (
		.clock(clock),
		.reset(reset),
		.imem_command(imem_command),
		.imem_addr(imem_addr),
		.dmem_command(dmem_command),
		.dmem_addr(dmem_addr),
		.dmem_data(dmem_data),
		.icache_response(icache_response),
		.dcache_response(dcache_response),
		.proc2mem_command(proc2mem_command),
		.proc2mem_addr(proc2mem_addr),
		.proc2mem_data(proc2mem_data),
		.mem2proc_response(mem2proc_response)
	);

endmodule

//--- tests/mem_model.sv
`timescale 1ns/1ps

module mem_model #(
	parameter logic [63:0] word_mult = 64'h1
) (
	input  logic                              clock,
	input  logic                              reset,
	// random choices made by the testbench
	input  logic                              busy_roll,
	input  logic [2:0]                        latency_roll,
	// memory bus
	input  front_pkg::bus_command_e           proc2mem_command,
	input  logic [front_pkg::xlen-1:0]        proc2mem_addr,
	input  logic [front_pkg::line_bits-1:0]   proc2mem_data,
	output logic [front_pkg::tag_bits-1:0]    mem2proc_response,
	output logic [front_pkg::tag_bits-1:0]    mem2proc_tag,
	output logic [front_pkg::line_bits-1:0]   mem2proc_data,
	// accepted commands so far
	output int                                load_count,
	output int                                store_count
);

	// sparse store map, untouched words follow the address rule
	logic [front_pkg::line_bits-1:0] store_map [logic [front_pkg::xlen-1:0]];

	// accepted loads not yet returned
	logic [front_pkg::tag_bits-1:0]  wait_tag [$];
	logic [front_pkg::line_bits-1:0] wait_data [$];
	int                              wait_due [$];

	logic [15:0]                    in_flight;
	logic [front_pkg::tag_bits-1:0] tag_counter;
	logic [front_pkg::tag_bits-1:0] free_tag;
	logic [front_pkg::tag_bits-1:0] scan_tag;
	int                             cycle;

	function automatic logic [63:0] word_at(input logic [31:0] addr);
		if (store_map.exists(addr)) begin
			return store_map[addr];
		end
		return {32'b0, addr} * word_mult + {32'b0, addr};
	endfunction

	// next tag from the counter, skipping tags in flight
	always_comb begin
		free_tag = '0;
		scan_tag = tag_counter;
		for (int i = 0; i < 15; i++) begin
			if (free_tag == '0 && !in_flight[scan_tag]) begin
				free_tag = scan_tag;
			end
			scan_tag = (scan_tag == 4'd15) ? 4'd1 : scan_tag + 4'd1;
		end
	end

	// accept in the same cycle unless busy
	assign mem2proc_response = (proc2mem_command != front_pkg::bus_none && !busy_roll) ?
		free_tag : '0;

	always @(posedge clock) begin
		logic [15:0] flight;
		int pick;
		if (reset) begin
			wait_tag.delete();
			wait_data.delete();
			wait_due.delete();
			in_flight <= '0;
			tag_counter <= 4'd1;
			mem2proc_tag <= '0;
			mem2proc_data <= '0;
			load_count <= 0;
			store_count <= 0;
			cycle = 0;
		end else begin
			cycle = cycle + 1;
			flight = in_flight;
			// tag on the return lines last cycle is free again
			if (mem2proc_tag != '0) begin
				flight[mem2proc_tag] = 1'b0;
			end
			if (mem2proc_response != '0) begin
				tag_counter <= (mem2proc_response == 4'd15) ? 4'd1 : mem2proc_response + 4'd1;
				if (proc2mem_command == front_pkg::bus_store) begin
					store_map[proc2mem_addr] = proc2mem_data;
					store_count <= store_count + 1;
				end else begin
					// load reads memory at acceptance
					wait_tag.push_back(mem2proc_response);
					wait_data.push_back(word_at(proc2mem_addr));
					wait_due.push_back(cycle + int'(latency_roll % 3'd6) + 1);
					flight[mem2proc_response] = 1'b1;
					load_count <= load_count + 1;
				end
			end
			// one return per cycle, oldest due first
			pick = -1;
			for (int i = 0; i < wait_tag.size(); i++) begin
				if (pick < 0 && wait_due[i] <= cycle) begin
					pick = i;
				end
			end
			if (pick >= 0) begin
				mem2proc_tag <= wait_tag[pick];
				mem2proc_data <= wait_data[pick];
				wait_tag.delete(pick);
				wait_data.delete(pick);
				wait_due.delete(pick);
			end else begin
				mem2proc_tag <= '0;
			end
			in_flight <= flight;
		end
	end

endmodule

//--- tests/mem_front_tb.sv
`timescale 1ns/1ps

module mem_front_tb;

	localparam int num_lines = 16;
	localparam int index_bits = $clog2(num_lines);
	localparam logic [15:0] lfsr_seed = 16'd63;
	localparam logic [15:0] lfsr_taps = 16'hB400;
	// odd multiplier of the untouched-word rule
	localparam logic [63:0] word_mult = 64'h9E37_79B9_7F4A_7C15;

	localparam int num_random_loads = 8;
	localparam int num_store_pairs = 4;
	localparam int num_mixed = 12;
	localparam int num_ops = 4 + num_random_loads + 2 * num_store_pairs + 2 * num_mixed;
	localparam int longest_latency = 6;
	// a few pipeline cycles plus busy retries on top of the latency
	localparam int timeout_cycles = num_ops * (longest_latency + 12) + 100;

	logic clock = 1'b0;
	logic reset;
	logic [31:0] fetch_addr;
	logic [63:0] fetch_data;
	logic fetch_valid;
	logic req_valid;
	logic req_store;
	logic [31:0] req_addr;
	logic [63:0] req_data;
	logic req_ready;
	logic resp_valid;
	logic [63:0] resp_data;
	front_pkg::bus_command_e proc2mem_command;
	logic [31:0] proc2mem_addr;
	logic [63:0] proc2mem_data;
	logic [3:0] mem2proc_response;
	logic [3:0] mem2proc_tag;
	logic [63:0] mem2proc_data;
	logic busy_roll;
	logic [2:0] latency_roll;
	int load_count;
	int store_count;

	// separate streams for stimulus and memory timing
	logic [15:0] stim_lfsr;
	logic [15:0] mem_lfsr;

	// shadow memory and shadow icache contents
	logic [63:0] shadow [logic [31:0]];
	logic [31:0] line_addr [num_lines];
	logic [num_lines-1:0] line_present = '0;
	logic [63:0] expected_resp [$];
	int expected_loads = 0;
	int expected_stores = 0;

	mem_front #(.num_lines(num_lines)) mem_front_inst (
		.clock(clock), .reset(reset),
		.fetch_addr(fetch_addr), .fetch_data(fetch_data), .fetch_valid(fetch_valid),
		.req_valid(req_valid), .req_store(req_store), .req_addr(req_addr),
		.req_data(req_data), .req_ready(req_ready),
		.resp_valid(resp_valid), .resp_data(resp_data),
		.proc2mem_command(proc2mem_command), .proc2mem_addr(proc2mem_addr),
		.proc2mem_data(proc2mem_data), .mem2proc_response(mem2proc_response),
		.mem2proc_tag(mem2proc_tag), .mem2proc_data(mem2proc_data)
	);

	mem_model #(.word_mult(word_mult)) mem_model_0 (
		.clock(clock), .reset(reset),
		.busy_roll(busy_roll), .latency_roll(latency_roll),
		.proc2mem_command(proc2mem_command), .proc2mem_addr(proc2mem_addr),
		.proc2mem_data(proc2mem_data), .mem2proc_response(mem2proc_response),
		.mem2proc_tag(mem2proc_tag), .mem2proc_data(mem2proc_data),
		.load_count(load_count), .store_count(store_count)
	);

	initial begin
		forever #2 clock = ~clock;
	end

	//////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////

	// galois LFSR, one step per bit
	function automatic logic [31:0] lfsr_bits(inout logic [15:0] state, input int count);
		logic [31:0] bits;
		bits = '0;
		for (int i = 0; i < count; i++) begin
			bits = {bits[30:0], state[0]};
			state = state[0] ? ((state >> 1) ^ lfsr_taps) : (state >> 1);
		end
		return bits;
	endfunction

	// fetch and data regions never overlap, stores skip the icache
	function automatic logic [31:0] fetch_address();
		return {12'h001, 17'(lfsr_bits(stim_lfsr, 17)), 3'b000};
	endfunction

	function automatic logic [31:0] data_address();
		return {12'h002, 17'(lfsr_bits(stim_lfsr, 17)), 3'b000};
	endfunction

	// expected word: last store, else the address rule
	function automatic logic [63:0] ref_word(input logic [31:0] addr);
		if (shadow.exists(addr)) begin
			return shadow[addr];
		end
		return {32'b0, addr} * word_mult + {32'b0, addr};
	endfunction

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] expected);
		if (got !== expected) begin
			$display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, expected);
			$display("Simulation FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic fetch_word(input logic [31:0] addr);
		logic [index_bits-1:0] index;
		logic expect_hit;
		index = addr[3 +: index_bits];
		expect_hit = line_present[index] && (line_addr[index] == addr);
		@(negedge clock);
		fetch_addr = addr;
		#1;
		// hit is combinational
		check_value("fetch_valid", 64'(fetch_valid), 64'(expect_hit));
		if (!expect_hit) begin
			expected_loads++;
		end
		while (!fetch_valid) begin
			@(negedge clock);
		end
		check_value("fetch_data", fetch_data, ref_word(addr));
		line_present[index] = 1'b1;
		line_addr[index] = addr;
	endtask

	task automatic data_op(input logic store, input logic [31:0] addr, input logic [63:0] data);
		@(negedge clock);
		while (!req_ready) begin
			@(negedge clock);
		end
		req_valid = 1'b1;
		req_store = store;
		req_addr = addr;
		req_data = data;
		if (!store) begin
			expected_resp.push_back(ref_word(addr));
			expected_loads++;
		end
		@(negedge clock);
		req_valid = 1'b0;
		// ready again once the port is done
		while (!req_ready) begin
			@(negedge clock);
		end
		if (store) begin
			shadow[addr] = data;
			expected_stores++;
		end
	endtask

	task automatic check_counts();
		check_value("load_count", 64'(load_count), 64'(expected_loads));
		check_value("store_count", 64'(store_count), 64'(expected_stores));
	endtask

	//////////////////////////////////////////////////
	// processes
	//////////////////////////////////////////////////

	// busy about one cycle in four, latency 1 to 6
	initial begin
		mem_lfsr = lfsr_seed;
		busy_roll = 1'b0;
		latency_roll = '0;
		forever begin
			@(negedge clock);
			busy_roll = (lfsr_bits(mem_lfsr, 2) == 32'd0);
			latency_roll = 3'(lfsr_bits(mem_lfsr, 3));
		end
	end

	// load results against the reference queue
	always @(negedge clock) begin
		if (resp_valid) begin
			if (expected_resp.size() == 0) begin
				$display("ERROR at %0t: resp_valid with no load outstanding", $time);
				$display("Simulation FAILED");
				$fatal(1, "unexpected load response");
			end else begin
				check_value("resp_data", resp_data, expected_resp.pop_front());
			end
		end
	end

	// instruction loads carry no write data
	always @(negedge clock) begin
		if (proc2mem_command == front_pkg::bus_load && proc2mem_addr[31:20] == 12'h001) begin
			check_value("proc2mem_data", proc2mem_data, 64'd0);
		end
	end

	initial begin
		repeat (timeout_cycles) @(posedge clock);
		$display("ERROR: no progress after %0d cycles, the DUT stopped answering",
			timeout_cycles);
		$display("Simulation FAILED");
		$fatal(1, "watchdog timeout");
	end

	initial begin
		logic [31:0] first_addr;
		logic [31:0] addr;
		logic [63:0] value;
		logic [31:0] mix_fetch [num_mixed];
		logic [31:0] mix_data [num_mixed];
		stim_lfsr = lfsr_seed;
		reset = 1'b1;
		fetch_addr = '0;
		req_valid = 1'b0;
		req_store = 1'b0;
		req_addr = '0;
		req_data = '0;
		first_addr = fetch_address();

		// 1. nothing valid while in reset
		repeat (2) begin
			@(negedge clock);
			fetch_addr = fetch_address();
			#1;
			check_value("fetch_valid", 64'(fetch_valid), 64'd0);
		end
		@(negedge clock);
		fetch_addr = first_addr;
		reset = 1'b0;
		@(negedge clock);
		check_value("proc2mem_command", 64'(proc2mem_command), 64'(front_pkg::bus_none));
		check_value("req_ready", 64'(req_ready), 64'd1);
		check_value("fetch_valid", 64'(fetch_valid), 64'd0);

		// 2. first miss, already under way
		fetch_word(first_addr);
		check_counts();

		// 3. hit, then a conflict on the same line
		fetch_word(first_addr);
		check_counts();
		fetch_word(first_addr ^ 32'h0000_0400);
		fetch_word(first_addr);
		check_counts();

		// 4. loads, then store and load back
		repeat (num_random_loads) data_op(1'b0, data_address(), '0);
		repeat (num_store_pairs) begin
			addr = data_address();
			value = {lfsr_bits(stim_lfsr, 32), 32'h0};
			value[31:0] = lfsr_bits(stim_lfsr, 32);
			data_op(1'b1, addr, value);
			data_op(1'b0, addr, '0);
		end
		check_counts();

		// 5. both sides at once
		for (int i = 0; i < num_mixed; i++) begin
			mix_fetch[i] = fetch_address();
			mix_data[i] = data_address();
		end
		fork
			for (int i = 0; i < num_mixed; i++) begin
				fetch_word(mix_fetch[i]);
			end
			for (int j = 0; j < num_mixed; j++) begin
				data_op(1'b0, mix_data[j], '0);
			end
		join
		// last response is compared on this edge
		@(negedge clock);
		check_counts();
		check_value("outstanding loads", 64'(expected_resp.size()), 64'd0);

		$display("Simulation PASSED");
		$finish;
	end

endmodule

//--- front.f
verilog/front_pkg.sv
verilog/icache.sv
verilog/data_port.sv
verilog/mem_arbiter.sv
verilog/mem_front.sv
tests/mem_model.sv
tests/mem_front_tb.sv

//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing
TOP      = mem_front_tb
FILELIST = front.f
BUILD    = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with $(TOOL) and run $(TOP)"
	@echo "  clean  remove $(BUILD)"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP)

clean:
	rm -rf $(BUILD)
